/* files.f */
fpga_core_pkg.sv
uart_rx.sv
uart_tx.sv
gmii_frame_fifo.sv
gmii_tx_ctrl.sv
fpga_core.sv
tb_fpga_core.sv

/* fpga_core.sv */
// FPGA core top level
`timescale 1ns/100ps

module fpga_core (
    input  wire logic                             clk,
    input  wire logic                             rst_n,

    // GPIO
    input  wire logic [7:0]                       sw,
    output wire logic [7:0]                       led,

    // UART, 115200 baud 8N1
    input  wire logic                             uart_rxd,
    output wire logic                             uart_txd,
    output wire logic                             uart_cts,

    // 1000BASE-T PHY, GMII
    output wire logic                             phy_reset_n,
    input  wire logic [fpga_core_pkg::GMII_W-1:0] phy_gmii_rxd,
    input  wire logic                             phy_gmii_rx_dv,
    input  wire logic                             phy_gmii_rx_er,
    output wire logic [fpga_core_pkg::GMII_W-1:0] phy_gmii_txd,
    output wire logic                             phy_gmii_tx_en,
    output wire logic                             phy_gmii_tx_er
);

    import fpga_core_pkg::*;

    logic [7:0]        rx_data;
    logic              rx_valid;
    logic              tx_ready;

    logic [GMII_W-1:0] fifo_data;
    logic              fifo_last;
    logic              fifo_valid;
    logic              fifo_ready;

    assign led = sw;

    // Always clear to send
    assign uart_cts = 1'b0;

    // PHY held in reset along with the core
    assign phy_reset_n = rst_n;

    // UART echo
    uart_rx u_uart_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rxd   (uart_rxd),
        .data  (rx_data),
        .valid (rx_valid),
        .ready (tx_ready)
    );

    uart_tx u_uart_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .data  (rx_data),
        .valid (rx_valid),
        .ready (tx_ready),
        .txd   (uart_txd)
    );

    // GMII frame loopback
    gmii_frame_fifo u_gmii_frame_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .rxd   (phy_gmii_rxd),
        .rx_dv (phy_gmii_rx_dv),
        .rx_er (phy_gmii_rx_er),
        .data  (fifo_data),
        .last  (fifo_last),
        .valid (fifo_valid),
        .ready (fifo_ready)
    );

    gmii_tx_ctrl u_gmii_tx_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .data  (fifo_data),
        .last  (fifo_last),
        .valid (fifo_valid),
        .ready (fifo_ready),
        .txd   (phy_gmii_txd),
        .tx_en (phy_gmii_tx_en),
        .tx_er (phy_gmii_tx_er)
    );

endmodule

/* fpga_core_pkg.sv */
// FPGA core shared constants
package fpga_core_pkg;

    // Core clock
    localparam int CLK_FREQ_HZ = 125000000;

    // UART, 8N1
    localparam int UART_BAUD = 115200;
    localparam int UART_CLKS_PER_BIT = CLK_FREQ_HZ / UART_BAUD;
    localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);

    // GMII byte lane
    localparam int GMII_W = 8;

    // Frame store depth is 2**FIFO_ADDR_W bytes
    localparam int FIFO_ADDR_W = 11;

    // 1518 byte frame plus preamble and SFD
    localparam int MAX_FRAME_LEN = 1526;
    localparam int FRAME_LEN_W = $clog2(MAX_FRAME_LEN + 1);

    // Minimum idle cycles between transmitted frames
    localparam int IFG_CYCLES = 12;
    localparam int IFG_CNT_W = $clog2(IFG_CYCLES + 1);

endpackage

/* gmii_frame_fifo.sv */
// GMII receive frame store
`timescale 1ns/100ps

module gmii_frame_fifo (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic [fpga_core_pkg::GMII_W-1:0] rxd,
    input  wire logic                             rx_dv,
    input  wire logic                             rx_er,
    output logic [fpga_core_pkg::GMII_W-1:0]      data,
    output logic                                  last,
    output logic                                  valid,
    input  wire logic                             ready
);

    import fpga_core_pkg::*;

    // Data byte with the end-of-frame flag on top
    logic [GMII_W:0]        mem [2**FIFO_ADDR_W];

    logic [FIFO_ADDR_W:0]   wr_ptr;
    logic [FIFO_ADDR_W:0]   wr_ptr_commit;
    logic [FIFO_ADDR_W:0]   rd_ptr;
    logic                   full;
    logic                   empty;

    logic                   hold_valid;
    logic [GMII_W-1:0]      hold_data;
    logic [FRAME_LEN_W-1:0] frame_len;
    logic                   drop;
    logic                   mem_we;
    logic                   mem_last;
    logic                   commit;

    logic                   rd_en;
    logic [GMII_W:0]        mem_q;
    logic                   mem_q_valid;
    logic                   out_load;

    // Full is judged on the tentative pointer
    assign full  = (wr_ptr == {~rd_ptr[FIFO_ADDR_W], rd_ptr[FIFO_ADDR_W-1:0]});
    assign empty = (rd_ptr == wr_ptr_commit);

    // The held byte is written once the next byte shows up or rx_dv falls,
    // so the final byte of a frame carries the last flag
    assign mem_we   = hold_valid && !drop && !full;
    assign mem_last = !rx_dv;
    assign commit   = mem_we && !rx_dv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            wr_ptr_commit <= '0;
            hold_valid    <= 1'b0;
            frame_len     <= '0;
            drop          <= 1'b0;
        end else begin
            if (mem_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (rx_dv) begin
                hold_valid <= 1'b1;
                if (!hold_valid) begin
                    // First byte of a new frame
                    frame_len <= FRAME_LEN_W'(1);
                    drop      <= rx_er;
                end else begin
                    if (frame_len != FRAME_LEN_W'(MAX_FRAME_LEN)) begin
                        frame_len <= frame_len + 1'b1;
                    end
                    // Error, overlength byte or no room left
                    if (rx_er || full || frame_len == FRAME_LEN_W'(MAX_FRAME_LEN)) begin
                        drop <= 1'b1;
                    end
                end
            end else if (hold_valid) begin
                hold_valid <= 1'b0;
                if (commit) begin
                    wr_ptr_commit <= wr_ptr + 1'b1;
                end else begin
                    // Bad frame, forget everything written for it
                    wr_ptr <= wr_ptr_commit;
                end
            end
        end
    end

    // Read side, memory stage then output prefetch register
    assign out_load = mem_q_valid && (!valid || ready);
    assign rd_en    = !empty && (!mem_q_valid || out_load);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr      <= '0;
            mem_q_valid <= 1'b0;
            valid       <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (rd_en) begin
                mem_q_valid <= 1'b1;
            end else if (out_load) begin
                mem_q_valid <= 1'b0;
            end

            if (out_load) begin
                valid <= 1'b1;
            end else if (ready) begin
                valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_dv) begin
            hold_data <= rxd;
        end
        if (mem_we) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= {mem_last, hold_data};
        end
        if (rd_en) begin
            mem_q <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
        end
        if (out_load) begin
            {last, data} <= mem_q;
        end
    end

endmodule

/* gmii_tx_ctrl.sv */
// GMII transmit control
`timescale 1ns/100ps

module gmii_tx_ctrl (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic [fpga_core_pkg::GMII_W-1:0] data,
    input  wire logic                             last,
    input  wire logic                             valid,
    output logic                                  ready,
    output logic [fpga_core_pkg::GMII_W-1:0]      txd,
    output logic                                  tx_en,
    output logic                                  tx_er
);

    import fpga_core_pkg::*;

    // Idle cycles still owed after the last frame
    logic [IFG_CNT_W-1:0] ifg_cnt;

    // Accept bytes only outside the gap
    assign ready = (ifg_cnt == '0);

    // Frames are forwarded clean, errors never sent
    assign tx_er = 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txd     <= '0;
            tx_en   <= 1'b0;
            ifg_cnt <= '0;
        end else begin
            if (valid && ready) begin
                txd   <= data;
                tx_en <= 1'b1;
                // Gap starts counting once the last byte is on the wire
                if (last) begin
                    ifg_cnt <= IFG_CNT_W'(IFG_CYCLES);
                end
            end else begin
                tx_en <= 1'b0;
                if (ifg_cnt != '0) begin
                    ifg_cnt <= ifg_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* tb_fpga_core.sv */
// FPGA core testbench
`timescale 1ns/100ps

module tb_fpga_core;

    import fpga_core_pkg::*;

    logic              clk;
    logic              rst_n;
    logic [7:0]        sw;
    logic [7:0]        led;
    logic              uart_rxd;
    logic              uart_txd;
    logic              uart_cts;
    logic              phy_reset_n;
    logic [GMII_W-1:0] phy_gmii_rxd;
    logic              phy_gmii_rx_dv;
    logic              phy_gmii_rx_er;
    logic [GMII_W-1:0] phy_gmii_txd;
    logic              phy_gmii_tx_en;
    logic              phy_gmii_tx_er;

    logic [31:0]       rng_state = 32'hae87_40bd;
    logic [7:0]        frame_q[$];
    logic [7:0]        exp_bytes[$];
    int                exp_lens[$];

    // Monitor state
    logic [7:0]        uart_q[$];
    int                u_cnt;
    int                u_bit;
    logic              u_busy;
    logic [7:0]        u_shreg;
    logic [7:0]        mon_bytes[$];
    int                mon_lens[$];
    int                mon_gaps[$];
    int                burst_len;
    int                idle_cnt;
    logic              in_burst;
    logic              er_seen;

    fpga_core u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .sw             (sw),
        .led            (led),
        .uart_rxd       (uart_rxd),
        .uart_txd       (uart_txd),
        .uart_cts       (uart_cts),
        .phy_reset_n    (phy_reset_n),
        .phy_gmii_rxd   (phy_gmii_rxd),
        .phy_gmii_rx_dv (phy_gmii_rx_dv),
        .phy_gmii_rx_er (phy_gmii_rx_er),
        .phy_gmii_txd   (phy_gmii_txd),
        .phy_gmii_tx_en (phy_gmii_tx_en),
        .phy_gmii_tx_er (phy_gmii_tx_er)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error [%s]: expected 0x%0h, actual 0x%0h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run aborted");
    endtask

    // UART monitor sampling each bit at its middle
    always @(negedge clk) begin
        if (!rst_n) begin
            u_busy = 1'b0;
        end else if (!u_busy) begin
            if (!uart_txd) begin
                u_busy = 1'b1;
                u_bit  = 0;
                u_cnt  = UART_CLKS_PER_BIT / 2 - 1;
            end
        end else if (u_cnt != 0) begin
            u_cnt--;
        end else begin
            u_cnt = UART_CLKS_PER_BIT - 1;
            if (u_bit == 0 && uart_txd) begin
                abort_run("UART transmit start bit went high before its middle");
            end else if (u_bit >= 1 && u_bit <= 8) begin
                u_shreg[u_bit-1] = uart_txd;
            end else if (u_bit == 9) begin
                if (!uart_txd) begin
                    abort_run("UART transmit stop bit was low");
                end else begin
                    uart_q.push_back(u_shreg);
                    u_busy = 1'b0;
                end
            end
            u_bit++;
        end
    end

    // GMII monitor with one entry per tx_en burst
    always @(posedge clk) begin
        if (!rst_n) begin
            in_burst  = 1'b0;
            burst_len = 0;
            idle_cnt  = 0;
        end else if (phy_gmii_tx_en) begin
            if (!in_burst) begin
                mon_gaps.push_back(idle_cnt);
                burst_len = 0;
            end
            mon_bytes.push_back(phy_gmii_txd);
            burst_len++;
            if (phy_gmii_tx_er) begin
                er_seen = 1'b1;
            end
            in_burst = 1'b1;
        end else begin
            if (in_burst) begin
                mon_lens.push_back(burst_len);
                idle_cnt = 1;
            end else begin
                idle_cnt++;
            end
            in_burst = 1'b0;
        end
    end

    // Start bit and 8 data bits LSB first, then the stop bit
    task automatic send_uart_byte(input logic [7:0] b, input logic bad_stop);
        logic [9:0] bits;
        int         i;
        bits = {~bad_stop, b, 1'b0};
        @(posedge clk);
        for (i = 0; i < 10; i++) begin
            uart_rxd <= bits[i];
            if (i == 9 && bad_stop) begin
                // Low across the middle and back high before the bit ends
                repeat (UART_CLKS_PER_BIT * 3 / 4) @(posedge clk);
                uart_rxd <= 1'b1;
                repeat (UART_CLKS_PER_BIT - UART_CLKS_PER_BIT * 3 / 4) @(posedge clk);
            end else begin
                repeat (UART_CLKS_PER_BIT) @(posedge clk);
            end
        end
        uart_rxd <= 1'b1;
    endtask

    task automatic wait_uart_bytes(input int n);
        int cycles;
        cycles = 0;
        while (uart_q.size() < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > 25 * UART_CLKS_PER_BIT) begin
                abort_run("Timeout waiting for the UART echo");
            end
        end
    endtask

    // Preamble and SFD, then random payload
    task automatic build_frame(input int len);
        int i;
        frame_q.delete();
        for (i = 0; i < len; i++) begin
            if (i < 7) begin
                frame_q.push_back(8'h55);
            end else if (i == 7) begin
                frame_q.push_back(8'hd5);
            end else begin
                frame_q.push_back(next_rand() & 32'hff);
            end
        end
    endtask

    task automatic expect_frame();
        int i;
        for (i = 0; i < frame_q.size(); i++) begin
            exp_bytes.push_back(frame_q[i]);
        end
        exp_lens.push_back(frame_q.size());
    endtask

    // er_pos below zero sends a clean frame
    task automatic send_frame(input int er_pos);
        int i;
        @(posedge clk);
        for (i = 0; i < frame_q.size(); i++) begin
            phy_gmii_rxd   <= frame_q[i];
            phy_gmii_rx_dv <= 1'b1;
            phy_gmii_rx_er <= (i == er_pos);
            @(posedge clk);
        end
        phy_gmii_rxd   <= '0;
        phy_gmii_rx_dv <= 1'b0;
        phy_gmii_rx_er <= 1'b0;
    endtask

    task automatic wait_frames(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (mon_lens.size() < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run("Timeout waiting for a frame on GMII transmit");
            end
        end
    endtask

    task automatic clear_frames();
        frame_q.delete();
        exp_bytes.delete();
        exp_lens.delete();
        mon_bytes.delete();
        mon_lens.delete();
        mon_gaps.delete();
        er_seen = 1'b0;
    endtask

    task automatic compare_frames(input string name);
        int i;
        check_equal(name, exp_lens.size(), mon_lens.size());
        for (i = 0; i < exp_lens.size(); i++) begin
            check_equal(name, exp_lens[i], mon_lens[i]);
        end
        for (i = 0; i < exp_bytes.size(); i++) begin
            check_equal(name, exp_bytes[i], mon_bytes[i]);
        end
        check_equal(name, 0, er_seen);
    endtask

    task automatic reset_and_leds();
        logic [31:0] v;
        int          i;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_equal("reset_and_leds", 0, phy_reset_n);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_equal("reset_and_leds", 1, phy_reset_n);
        check_equal("reset_and_leds", 1, uart_txd);
        check_equal("reset_and_leds", 0, uart_cts);
        check_equal("reset_and_leds", 0, phy_gmii_tx_en);
        check_equal("reset_and_leds", 0, phy_gmii_tx_er);
        for (i = 0; i < 6; i++) begin
            v = next_rand();
            @(posedge clk);
            sw <= v[7:0];
            @(negedge clk);
            check_equal("reset_and_leds", v[7:0], led);
        end
    endtask

    task automatic uart_echo();
        logic [7:0] b;
        int         i;
        uart_q.delete();
        for (i = 0; i < 8; i++) begin
            b = next_rand() & 32'hff;
            send_uart_byte(b, 1'b0);
            wait_uart_bytes(i + 1);
            check_equal("uart_echo", b, uart_q[i]);
        end
        // Framing error then a good byte
        uart_q.delete();
        send_uart_byte(8'h3c, 1'b1);
        repeat (2 * UART_CLKS_PER_BIT) @(posedge clk);
        b = next_rand() & 32'hff;
        send_uart_byte(b, 1'b0);
        wait_uart_bytes(1);
        repeat (15 * UART_CLKS_PER_BIT) @(posedge clk);
        check_equal("uart_bad_stop", 1, uart_q.size());
        check_equal("uart_bad_stop", b, uart_q[0]);
    endtask

    task automatic frame_loopback();
        clear_frames();
        build_frame(64 + next_rand() % 137);
        expect_frame();
        send_frame(-1);
        wait_frames(1, 2000);
        repeat (100) @(posedge clk);
        compare_frames("frame_loopback");
    endtask

    task automatic error_drop();
        int len;
        clear_frames();
        len = 64 + next_rand() % 137;
        build_frame(len);
        send_frame(8 + next_rand() % (len - 8));
        repeat (11) @(posedge clk);
        build_frame(64 + next_rand() % 137);
        expect_frame();
        send_frame(-1);
        wait_frames(1, 2000);
        repeat (100) @(posedge clk);
        compare_frames("error_drop");
    endtask

    task automatic oversize_order();
        clear_frames();
        build_frame(64 + next_rand() % 137);
        expect_frame();
        send_frame(-1);
        repeat (11) @(posedge clk);
        build_frame(MAX_FRAME_LEN + 1);
        send_frame(-1);
        repeat (11) @(posedge clk);
        build_frame(64 + next_rand() % 137);
        expect_frame();
        send_frame(-1);
        wait_frames(2, 3000);
        repeat (100) @(posedge clk);
        compare_frames("oversize_order");
        // Short frame committed while a long one is still going out
        clear_frames();
        build_frame(150 + next_rand() % 51);
        expect_frame();
        send_frame(-1);
        repeat (11) @(posedge clk);
        build_frame(64 + next_rand() % 9);
        expect_frame();
        send_frame(-1);
        wait_frames(2, 2000);
        repeat (100) @(posedge clk);
        compare_frames("frame_gap");
        check_equal("frame_gap", 1, mon_gaps[1] >= IFG_CYCLES);
    endtask

    initial begin
        rst_n          = 1'b0;
        sw             = '0;
        uart_rxd       = 1'b1;
        phy_gmii_rxd   = '0;
        phy_gmii_rx_dv = 1'b0;
        phy_gmii_rx_er = 1'b0;
        er_seen        = 1'b0;
        reset_and_leds();
        uart_echo();
        frame_loopback();
        error_drop();
        oversize_order();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* uart_rx.sv */
// UART receiver
`timescale 1ns/100ps

module uart_rx (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       rxd,
    output logic [7:0]      data,
    output logic            valid,
    input  wire logic       ready
);

    import fpga_core_pkg::*;

    logic                  rxd_meta;
    logic                  rxd_sync;
    logic                  busy;
    logic [3:0]            bit_idx;
    logic [UART_CNT_W-1:0] baud_cnt;
    logic [7:0]            shreg;
    logic                  sample;
    logic                  shift_en;
    logic                  store;

    // Line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
    assign sample   = busy && (baud_cnt == '0);
    assign shift_en = sample && (bit_idx != 4'd0) && (bit_idx != 4'd9);

    // Keep the byte only on a good stop bit and a free holding register
    assign store = sample && (bit_idx == 4'd9) && rxd_sync && (!valid || ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            bit_idx  <= '0;
            baud_cnt <= '0;
            valid    <= 1'b0;
        end else begin
            if (store) begin
                valid <= 1'b1;
            end else if (ready) begin
                valid <= 1'b0;
            end

            if (!busy) begin
                if (!rxd_sync) begin
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    // Land on mid-bit, less the synchronizer delay
                    baud_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 2);
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT - 1);
                bit_idx  <= bit_idx + 1'b1;
                // Start bit gone high again, treat as a glitch
                if (bit_idx == 4'd0 && rxd_sync) begin
                    busy <= 1'b0;
                end
                if (bit_idx == 4'd9) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
        if (store) begin
            data <= shreg;
        end
    end

endmodule

/* uart_tx.sv */
// UART transmitter
`timescale 1ns/100ps

module uart_tx (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [7:0] data,
    input  wire logic       valid,
    output logic            ready,
    output logic            txd
);

    import fpga_core_pkg::*;

    logic                  busy;
    logic [3:0]            bit_cnt;
    logic [UART_CNT_W-1:0] baud_cnt;
    // Data bits then stop bit, shifted out LSB first
    logic [8:0]            shreg;

    assign ready = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            baud_cnt <= '0;
            shreg    <= '1;
            txd      <= 1'b1;
        end else begin
            if (!busy) begin
                if (valid) begin
                    // Start bit goes out right away
                    busy     <= 1'b1;
                    txd      <= 1'b0;
                    shreg    <= {1'b1, data};
                    bit_cnt  <= '0;
                    baud_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT - 1);
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else if (bit_cnt == 4'd9) begin
                // Stop bit done
                busy <= 1'b0;
            end else begin
                txd      <= shreg[0];
                shreg    <= {1'b1, shreg[8:1]};
                bit_cnt  <= bit_cnt + 1'b1;
                baud_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT - 1);
            end
        end
    end

endmodule
